/* Bender.yml */
package:
  name: rv32_mem_wb

sources:
  - include_dirs:
      - design
    files:
      - design/rv32_wb_pkg.sv
      - design/mem_bus_if.sv
      - design/mem_seq_fsm.sv
      - design/wait_timer.sv
      - design/store_align.sv
      - design/data_sram.sv
      - design/regfile_mux.sv
      - design/regfile.sv
      - design/rv32_mem_wb.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/rv32_mem_wb_asserts.sv
      - tb/tb_rv32_mem_wb.sv

/* design/data_sram.sv */
`include "rv32_wb_consts.svh"

module data_sram
    import rv32_wb_pkg::*;
(
    input  logic   clk,
    mem_bus_if.mem bus
);

    rv32_word mem [`WB_MEM_WORDS];

    // Masked byte write.
    always_ff @(posedge clk) begin
        if (bus.req && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.wmask[i]) begin
                    mem[bus.word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read, held until the next read.
    always_ff @(posedge clk) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= mem[bus.word_addr];
        end
    end

endmodule

/* design/mem_bus_if.sv */
`include "rv32_wb_consts.svh"

interface mem_bus_if;

    localparam int AW = $clog2(`WB_MEM_WORDS);

    logic          req;        // One-cycle access strobe.
    logic          we;
    logic [AW-1:0] word_addr;
    logic [3:0]    wmask;      // Byte lanes written on a store.
    logic [31:0]   wdata;
    logic [31:0]   rdata;

    modport seq (output req, we, word_addr);

    modport align (output wmask, wdata);

    modport mem (
        input  req, we, word_addr, wmask, wdata,
        output rdata
    );

endinterface

/* design/mem_seq_fsm.sv */
`include "rv32_wb_consts.svh"

module mem_seq_fsm
    import rv32_wb_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            op_valid,
    input  wb_op_e          op,
    input  rv32_word        addr,
    input  rv32_word        alu_result,
    input  rv32_word        u_imm,
    input  rv32_word        pc,
    input  logic            br_flag,
    input  logic [4:0]      rd,
    mem_bus_if.seq          bus,
    output logic            timer_start,
    input  logic            timer_expired,
    output logic            busy,
    output logic            done,
    output logic            rf_we,
    output regfilemux_sel_e wb_sel,
    output wb_op_e          cap_op,
    output rv32_word        cap_addr,
    output rv32_word        cap_alu,
    output rv32_word        cap_uimm,
    output rv32_word        cap_pc,
    output logic            cap_br,
    output logic [4:0]      wb_rd
);

    localparam int AW = $clog2(`WB_MEM_WORDS);

    seq_state_e state, state_next;
    logic       accept;
    logic       in_is_mem;
    logic       cap_store;

    assign accept    = op_valid && (state == IDLE); // Strobes while busy are dropped.
    assign in_is_mem = op inside {op_lw, op_lh, op_lhu, op_lb, op_lbu, op_sw, op_sh, op_sb};
    assign cap_store = cap_op inside {op_sw, op_sh, op_sb};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Operand set, held for the whole operation.
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_op   <= op;
            cap_addr <= addr;
            cap_alu  <= alu_result;
            cap_uimm <= u_imm;
            cap_pc   <= pc;
            cap_br   <= br_flag;
            wb_rd    <= rd;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = in_is_mem ? ACCESS : WRITEBACK;
                end
            end
            ACCESS:    state_next = WAIT;
            WAIT:      state_next = timer_expired ? WRITEBACK : WAIT;
            WRITEBACK: state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_comb begin
        case (cap_op)
            op_br:   wb_sel = rv32_wb_pkg::br_en;
            op_lui:  wb_sel = rv32_wb_pkg::u_imm;
            op_jal:  wb_sel = rv32_wb_pkg::pc_plus4;
            op_lw:   wb_sel = rv32_wb_pkg::lw;
            op_lh:   wb_sel = rv32_wb_pkg::lh;
            op_lhu:  wb_sel = rv32_wb_pkg::lhu;
            op_lb:   wb_sel = rv32_wb_pkg::lb;
            op_lbu:  wb_sel = rv32_wb_pkg::lbu;
            default: wb_sel = rv32_wb_pkg::alu_out; // Stores never reach the regfile.
        endcase
    end

    assign busy          = (state != IDLE);
    assign done          = (state == WRITEBACK);
    assign timer_start   = (state == ACCESS);
    assign bus.req       = (state == ACCESS);
    assign bus.we        = (state == ACCESS) && cap_store;
    assign bus.word_addr = cap_addr[AW+1:2];
    assign rf_we         = done && !cap_store && (wb_rd != 5'd0);

endmodule

/* design/regfile.sv */
`include "rv32_wb_consts.svh"

module regfile
    import rv32_wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       we,
    input  logic [4:0] waddr,
    input  logic [4:0] raddr,
    input  rv32_word   wdata,
    output rv32_word   rdata
);

    rv32_word regs [`WB_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero even before the first reset.
    assign rdata = (raddr == 5'd0) ? '0 : regs[raddr];

endmodule

/* design/regfile_mux.sv */
module regfile_mux
    import rv32_wb_pkg::*;
(
    input  regfilemux_sel_e sel,
    input  logic [3:0]      byte_enable,
    input  rv32_word        alu_out,
    input  rv32_word        u_imm,
    input  rv32_word        pc,
    input  rv32_word        mdr,
    input  logic            br_en,
    output rv32_word        wb_data
);

    always_comb begin
        wb_data = alu_out;

        case (sel)
            rv32_wb_pkg::alu_out:  wb_data = alu_out;
            rv32_wb_pkg::br_en:    wb_data = {31'b0, br_en};
            rv32_wb_pkg::u_imm:    wb_data = u_imm;
            rv32_wb_pkg::pc_plus4: wb_data = pc + 32'd4;
            rv32_wb_pkg::lw:       wb_data = mdr;

            rv32_wb_pkg::lb:
                case (byte_enable)
                    4'b0001: wb_data = {{24{mdr[7]}}, mdr[7:0]};
                    4'b0010: wb_data = {{24{mdr[15]}}, mdr[15:8]};
                    4'b0100: wb_data = {{24{mdr[23]}}, mdr[23:16]};
                    4'b1000: wb_data = {{24{mdr[31]}}, mdr[31:24]};
                    default: wb_data = mdr;
                endcase

            rv32_wb_pkg::lbu:
                case (byte_enable)
                    4'b0001: wb_data = {24'b0, mdr[7:0]};
                    4'b0010: wb_data = {24'b0, mdr[15:8]};
                    4'b0100: wb_data = {24'b0, mdr[23:16]};
                    4'b1000: wb_data = {24'b0, mdr[31:24]};
                    default: wb_data = mdr;
                endcase

            rv32_wb_pkg::lh:
                case (byte_enable)
                    4'b0011: wb_data = {{16{mdr[15]}}, mdr[15:0]};
                    4'b1100: wb_data = {{16{mdr[31]}}, mdr[31:16]};
                    default: wb_data = mdr;
                endcase

            rv32_wb_pkg::lhu:
                case (byte_enable)
                    4'b0011: wb_data = {16'b0, mdr[15:0]};
                    4'b1100: wb_data = {16'b0, mdr[31:16]};
                    default: wb_data = mdr;
                endcase

            default: wb_data = alu_out; // Unknown select.
        endcase
    end

endmodule

/* design/rv32_mem_wb.sv */
module rv32_mem_wb
    import rv32_wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       op_valid,
    input  wb_op_e     op,
    input  rv32_word   addr,
    input  rv32_word   alu_result,
    input  logic       br_flag,
    input  rv32_word   u_imm,
    input  rv32_word   pc,
    input  rv32_word   store_data,
    input  logic [4:0] rd,
    input  logic [4:0] read_addr,
    output logic       busy,
    output logic       done,
    output rv32_word   read_data
);

    logic            timer_start;
    logic            timer_expired;
    logic            rf_we;
    regfilemux_sel_e wb_sel;
    wb_op_e          cap_op;
    rv32_word        cap_addr;
    rv32_word        cap_alu;
    rv32_word        cap_uimm;
    rv32_word        cap_pc;
    logic            cap_br;
    logic [4:0]      wb_rd;
    rv32_word        cap_store_data;
    logic [3:0]      byte_enable;
    rv32_word        wb_data;

    mem_bus_if mem_bus ();

    // Store data is captured alongside the operand set.
    always_ff @(posedge clk) begin
        if (op_valid && !busy) begin
            cap_store_data <= store_data;
        end
    end

    mem_seq_fsm mem_seq_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op           (op),
        .addr         (addr),
        .alu_result   (alu_result),
        .u_imm        (u_imm),
        .pc           (pc),
        .br_flag      (br_flag),
        .rd           (rd),
        .bus          (mem_bus.seq),
        .timer_start  (timer_start),
        .timer_expired(timer_expired),
        .busy         (busy),
        .done         (done),
        .rf_we        (rf_we),
        .wb_sel       (wb_sel),
        .cap_op       (cap_op),
        .cap_addr     (cap_addr),
        .cap_alu      (cap_alu),
        .cap_uimm     (cap_uimm),
        .cap_pc       (cap_pc),
        .cap_br       (cap_br),
        .wb_rd        (wb_rd)
    );

    wait_timer wait_timer_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (timer_start),
        .expired(timer_expired)
    );

    store_align store_align_inst (
        .op         (cap_op),
        .addr       (cap_addr),
        .store_data (cap_store_data),
        .bus        (mem_bus.align),
        .byte_enable(byte_enable)
    );

    data_sram data_sram_inst (
        .clk(clk),
        .bus(mem_bus.mem)
    );

    regfile_mux regfile_mux_inst (
        .sel        (wb_sel),
        .byte_enable(byte_enable),
        .alu_out    (cap_alu),
        .u_imm      (cap_uimm),
        .pc         (cap_pc),
        .mdr        (mem_bus.rdata),
        .br_en      (cap_br),
        .wb_data    (wb_data)
    );

    regfile regfile_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .we   (rf_we),
        .waddr(wb_rd),
        .raddr(read_addr),
        .wdata(wb_data),
        .rdata(read_data)
    );

endmodule

/* design/rv32_wb_consts.svh */
`ifndef RV32_WB_CONSTS_SVH
`define RV32_WB_CONSTS_SVH

// Fixed memory wait states after the access cycle.
`define WB_MEM_WAIT 3

// Data memory depth in 32-bit words.
`define WB_MEM_WORDS 64

`define WB_NUM_REGS 32

`endif

/* design/rv32_wb_pkg.sv */
package rv32_wb_pkg;

    typedef logic [31:0] rv32_word;

    typedef enum logic [3:0] {
        op_alu,
        op_br,
        op_lui,
        op_jal,
        op_lw,
        op_lh,
        op_lhu,
        op_lb,
        op_lbu,
        op_sw,
        op_sh,
        op_sb
    } wb_op_e;

    // Register file write source.
    typedef enum logic [3:0] {
        alu_out,
        br_en,
        u_imm,
        pc_plus4,
        lw,
        lh,
        lhu,
        lb,
        lbu
    } regfilemux_sel_e;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WAIT,
        WRITEBACK
    } seq_state_e;

endpackage

/* design/store_align.sv */
module store_align
    import rv32_wb_pkg::*;
(
    input  wb_op_e     op,
    input  rv32_word   addr,
    input  rv32_word   store_data,
    mem_bus_if.align   bus,
    output logic [3:0] byte_enable
);

    logic is_store;

    assign is_store = op inside {op_sw, op_sh, op_sb};

    // Lane select, shared by loads and stores.
    always_comb begin
        case (op)
            op_lw, op_sw:         byte_enable = 4'b1111;
            op_lh, op_lhu, op_sh: byte_enable = addr[1] ? 4'b1100 : 4'b0011;
            op_lb, op_lbu, op_sb: byte_enable = 4'b0001 << addr[1:0];
            default:              byte_enable = 4'b0000;
        endcase
    end

    // Replicate the low bits so any enabled lane sees them.
    always_comb begin
        case (op)
            op_sh:   bus.wdata = {2{store_data[15:0]}};
            op_sb:   bus.wdata = {4{store_data[7:0]}};
            default: bus.wdata = store_data;
        endcase
    end

    assign bus.wmask = is_store ? byte_enable : 4'b0000;

endmodule

/* design/wait_timer.sv */
`include "rv32_wb_consts.svh"

module wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic expired
);

    localparam int CW = $clog2(`WB_MEM_WAIT + 1);

    logic [CW-1:0] count;
    logic          active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count  <= '0;
            active <= 1'b0;
        end else if (start) begin
            count  <= CW'(`WB_MEM_WAIT - 1); // Last wait cycle is the one at zero.
            active <= 1'b1;
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign expired = active && (count == '0);

endmodule

/* sim.f */
+incdir+design
design/rv32_wb_pkg.sv
design/mem_bus_if.sv
design/mem_seq_fsm.sv
design/wait_timer.sv
design/store_align.sv
design/data_sram.sv
design/regfile_mux.sv
design/regfile.sv
design/rv32_mem_wb.sv
tb/rv32_mem_wb_asserts.sv
tb/tb_rv32_mem_wb.sv

/* tb/rv32_mem_wb_asserts.sv */
module rv32_mem_wb_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        busy,
    input logic        done,
    input logic [4:0]  read_addr,
    input logic [31:0] read_data
);

    int fail_count = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    done_needs_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else begin
            fail_count++;
            $error("done was high while busy was low");
        end

    // x0 is hardwired to zero.
    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (read_addr == 5'd0) |-> (read_data == 32'd0))
        else begin
            fail_count++;
            $error("register x0 read back a nonzero value");
        end

    // Reset is synchronous, so busy clears one edge later.
    busy_low_in_reset: assert property (@(posedge clk) !rst_n |=> !busy)
        else begin
            fail_count++;
            $error("busy was high during reset");
        end

endmodule

bind rv32_mem_wb rv32_mem_wb_asserts asserts_inst (.*);

/* tb/tb_rv32_mem_wb.sv */
`include "rv32_wb_consts.svh"

module tb_rv32_mem_wb
    import rv32_wb_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       op_valid;
    wb_op_e     op;
    rv32_word   addr;
    rv32_word   alu_result;
    logic       br_flag;
    rv32_word   u_imm;
    rv32_word   pc;
    rv32_word   store_data;
    logic [4:0] rd;
    logic [4:0] read_addr;
    logic       busy;
    logic       done;
    rv32_word   read_data;

    rv32_word shadow_mem [`WB_MEM_WORDS]; // Starts as X, like the SRAM.
    rv32_word shadow_reg [`WB_NUM_REGS];
    int       errors = 0;
    int       test_start_errors;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       cycle_count = 0;
    string    cur_test;

    rv32_mem_wb rv32_mem_wb_inst (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 2000) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input rv32_word expected, input rv32_word actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst_n    = 1'b0;
        op_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (shadow_reg[i]) shadow_reg[i] = '0;
    endtask

    function automatic rv32_word rand_addr();
        return {24'b0, 6'($urandom_range(63)), 2'b00};
    endfunction

    // Writeback value of an operation, worked out from the ISA rules.
    function automatic rv32_word expect_wb(wb_op_e o, rv32_word a, rv32_word v);
        rv32_word    w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow_mem[a[7:2]];
        b = w[8*a[1:0] +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (o)
            op_br:   return {31'b0, v[0]};
            op_jal:  return v + 32'd4;
            op_lw:   return w;
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'b0, h};
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'b0, b};
            default: return v;
        endcase
    endfunction

    task automatic shadow_store(input wb_op_e o, input rv32_word a, input rv32_word v);
        case (o)
            op_sw:   shadow_mem[a[7:2]] = v;
            op_sh:   shadow_mem[a[7:2]][16*a[1] +: 16] = v[15:0];
            op_sb:   shadow_mem[a[7:2]][8*a[1:0] +: 8] = v[7:0];
            default: ;
        endcase
    endtask

    // One strobe, then wait for done. A nonzero stray_rd adds a second strobe while busy.
    task automatic issue_op(input wb_op_e o, input logic [4:0] r, input rv32_word a,
                            input rv32_word v, input logic [4:0] stray_rd = 5'd0);
        int       lat;
        rv32_word exp_val;
        logic     is_mem;
        is_mem  = o inside {op_lw, op_lh, op_lhu, op_lb, op_lbu, op_sw, op_sh, op_sb};
        exp_val = expect_wb(o, a, v);
        op         = o;
        rd         = r;
        addr       = a;
        alu_result = v;
        u_imm      = v;
        pc         = v;
        store_data = v;
        br_flag    = v[0];
        op_valid   = 1'b1;
        @(posedge clk);
        #1;
        lat = 1;
        if (stray_rd != 5'd0) begin
            op         = op_alu;
            rd         = stray_rd;
            alu_result = ~v;
        end else begin
            op_valid = 1'b0;
        end
        while (!done) begin
            @(posedge clk);
            #1;
            op_valid = 1'b0;
            lat++;
        end
        check_val({cur_test, " latency"}, is_mem ? 2 + `WB_MEM_WAIT : 1, lat);
        @(posedge clk); // Register write lands on this edge.
        #1;
        op_valid = 1'b0;
        if (o inside {op_sw, op_sh, op_sb}) begin
            shadow_store(o, a, v);
        end else if (r != 5'd0) begin
            shadow_reg[r] = exp_val;
        end
    endtask

    task automatic check_reg(input logic [4:0] r);
        read_addr = r;
        #1;
        check_val($sformatf("%s x%0d", cur_test, r), shadow_reg[r], read_data);
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        cur_test          = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
            $display("%s: FAIL", cur_test);
        end else begin
            $display("%s: ok", cur_test);
        end
    endtask

    task automatic test_pass_through();
        wb_op_e pass_ops [4] = '{op_alu, op_br, op_lui, op_jal};
        begin_test("pass_through");
        for (int i = 0; i < 4; i++) begin
            issue_op(pass_ops[i], 5'(i + 1), '0, $urandom);
            check_reg(5'(i + 1));
        end
        end_test();
    endtask

    task automatic test_word_mem();
        rv32_word a;
        begin_test("word_store_load");
        for (int i = 0; i < 6; i++) begin
            a = rand_addr();
            issue_op(op_sw, 5'd4, a, $urandom); // Store must not touch x4.
            issue_op(op_lw, 5'(5 + i), a, '0);
            check_reg(5'(5 + i));
            check_reg(5'd4);
        end
        end_test();
    endtask

    task automatic test_subword_store();
        rv32_word a;
        begin_test("subword_store");
        a = rand_addr();
        issue_op(op_sw, 5'd0, a, $urandom);
        for (int off = 0; off < 4; off++) begin
            issue_op(op_sb, 5'd0, a + off, $urandom);
            issue_op(op_lw, 5'd16, a, '0);
            check_reg(5'd16);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_op(op_sh, 5'd0, a + off, $urandom);
            issue_op(op_lw, 5'd17, a, '0);
            check_reg(5'd17);
        end
        end_test();
    endtask

    task automatic test_subword_load();
        rv32_word a;
        rv32_word w;
        begin_test("subword_load");
        for (int k = 0; k < 2; k++) begin
            a = rand_addr();
            w = (k == 0) ? ($urandom | 32'h8080_8080) : ($urandom & 32'h7f7f_7f7f);
            issue_op(op_sw, 5'd0, a, w);
            for (int off = 0; off < 4; off++) begin
                issue_op(op_lb, 5'd18, a + off, '0);
                issue_op(op_lbu, 5'd19, a + off, '0);
                check_reg(5'd18);
                check_reg(5'd19);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_op(op_lh, 5'd20, a + off, '0);
                issue_op(op_lhu, 5'd21, a + off, '0);
                check_reg(5'd20);
                check_reg(5'd21);
            end
        end
        end_test();
    endtask

    task automatic test_ignored_and_x0();
        rv32_word a;
        begin_test("ignored_strobe_x0");
        a = rand_addr();
        issue_op(op_alu, 5'd22, '0, $urandom);
        issue_op(op_sw, 5'd0, a, $urandom);
        issue_op(op_lw, 5'd23, a, '0, 5'd22); // Second strobe targets x22.
        check_reg(5'd22);
        check_reg(5'd23);
        issue_op(op_alu, 5'd0, '0, $urandom);
        check_reg(5'd0);
        issue_op(op_lw, 5'd0, a, '0);
        check_reg(5'd0);
        end_test();
    endtask

    task automatic test_mid_reset();
        begin_test("mid_run_reset");
        op       = op_lw;
        addr     = rand_addr();
        rd       = 5'd24;
        op_valid = 1'b1;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        check_val({cur_test, " busy before reset"}, 32'd1, busy);
        rst_n = 1'b0;
        // Spans the cycles in which the load would otherwise finish.
        for (int i = 0; i < 2 + `WB_MEM_WAIT; i++) begin
            @(posedge clk);
            #1;
            check_val({cur_test, " busy"}, '0, busy);
            check_val({cur_test, " done"}, '0, done);
        end
        apply_reset();
        for (int i = 0; i < `WB_NUM_REGS; i++) begin
            check_reg(5'(i));
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h4134054c));
        rst_n      = 1'b0;
        op_valid   = 1'b0;
        op         = op_alu;
        addr       = '0;
        alu_result = '0;
        br_flag    = 1'b0;
        u_imm      = '0;
        pc         = '0;
        store_data = '0;
        rd         = '0;
        read_addr  = '0;
        apply_reset();
        test_pass_through();
        test_word_mem();
        test_subword_store();
        test_subword_load();
        test_ignored_and_x0();
        test_mid_reset();
        $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion errors: %0d",
                 tests_run, tests_failed, errors, rv32_mem_wb_inst.asserts_inst.fail_count);
        if (errors == 0 && tests_failed == 0 && rv32_mem_wb_inst.asserts_inst.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
